//--- Makefile
VERILATOR       ?= verilator
TOP             ?= tb_top
FILE_LIST       ?= compile.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert
RUN_ARGS        ?= +verilator+error+limit+100
PASS_MESSAGE    ?= Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

//--- common/daq_defs.svh
`ifndef DAQ_DEFS_SVH
`define DAQ_DEFS_SVH

// number of trigger channels in the front end
`define DAQ_NUM_CHANNELS 4

// raw and corrected samples share the ADC sample width
`define DAQ_SAMPLE_WIDTH 16

// the high-gain baseline keeps one sign bit above a 12-bit range
`define DAQ_HG_BASELINE_WIDTH 13

// deepest pre-trigger history the delay line can replay
`define DAQ_MAX_PRE_LENGTH 8

// longest tail after the trigger sample
`define DAQ_MAX_POST_LENGTH 8

`endif

//--- common/daq_pkg.sv
`include "daq_defs.svh"

package daq_pkg;

    typedef logic signed [`DAQ_SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [`DAQ_SAMPLE_WIDTH-1:0] threshold_t;
    typedef logic signed [`DAQ_HG_BASELINE_WIDTH-1:0] hg_baseline_t;
    typedef logic signed [`DAQ_SAMPLE_WIDTH-1:0] lg_baseline_t;

    // lengths hold 0 up to the maximum inclusive
    typedef logic [$clog2(`DAQ_MAX_PRE_LENGTH+1)-1:0] pre_length_t;
    typedef logic [$clog2(`DAQ_MAX_POST_LENGTH+1)-1:0] post_length_t;

    // bit 0 rising enable, bit 1 falling enable, bit 2 high-gain baseline, bit 3 invert
    typedef logic [3:0] trigger_type_t;

    typedef enum logic [1:0] {
        ACQ_IDLE       = 2'd0,
        ACQ_SINGLE     = 2'd1,
        ACQ_CONTINUOUS = 2'd2,
        ACQ_RESERVED   = 2'd3
    } acquire_mode_e;

    typedef struct packed {
        logic          stop;
        acquire_mode_e acquire_mode;
        trigger_type_t trigger_type;
        threshold_t    rising_threshold;
        threshold_t    falling_threshold;
        hg_baseline_t  hg_baseline;
        lg_baseline_t  lg_baseline;
        pre_length_t   pre_length;
        post_length_t  post_length;
    } trigger_control_t;

    typedef struct packed {
        logic    valid;
        logic    first;
        logic    last;
        sample_t sample;
    } window_sample_t;

endpackage

//--- compile.f
+incdir+common
common/daq_pkg.sv
rtl/control_distributor.sv
trigger_channel/trigger_channel.sv
rtl/event_collector.sv
rtl/digitizer_trigger_top.sv
tb/trigger_props.sv
tb/tb_top.sv

//--- rtl/control_distributor.sv
`timescale 1ns/100ps
`include "daq_defs.svh"

module control_distributor
    import daq_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             cfg_write,
    input  trigger_control_t cfg_data,
    output trigger_control_t channel_control [`DAQ_NUM_CHANNELS]
);

    // channels come up stopped and idle until software writes a word
    localparam trigger_control_t control_default = '{
        stop:         1'b1,
        acquire_mode: ACQ_IDLE,
        default:      '0
    };

    // each channel gets its own register so the copies can be placed
    // next to their channel; all of them load from the same strobe
    for (genvar i = 0; i < `DAQ_NUM_CHANNELS; i++) begin : gen_copy
        always_ff @(posedge clk) begin
            if (rst) begin
                channel_control[i] <= control_default;
            end else if (cfg_write) begin
                channel_control[i] <= cfg_data;
            end
        end
    end

endmodule

//--- rtl/digitizer_trigger_top.sv
`timescale 1ns/100ps
`include "daq_defs.svh"

module digitizer_trigger_top
    import daq_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         cfg_write,
    input  trigger_control_t             cfg_data,
    input  logic                         sample_valid,
    input  sample_t                      adc_samples [`DAQ_NUM_CHANNELS],
    output window_sample_t               window_out [`DAQ_NUM_CHANNELS],
    output logic                         trigger_pattern_valid,
    output logic [`DAQ_NUM_CHANNELS-1:0] trigger_pattern,
    output logic [15:0]                  event_count
);

    trigger_control_t channel_control [`DAQ_NUM_CHANNELS];
    window_sample_t   channel_windows [`DAQ_NUM_CHANNELS];

    control_distributor u_control_distributor (
        .clk             (clk),
        .rst             (rst),
        .cfg_write       (cfg_write),
        .cfg_data        (cfg_data),
        .channel_control (channel_control)
    );

    for (genvar i = 0; i < `DAQ_NUM_CHANNELS; i++) begin : gen_channel
        trigger_channel u_trigger_channel (
            .clk          (clk),
            .rst          (rst),
            .control      (channel_control[i]),
            .sample_valid (sample_valid),
            .adc_sample   (adc_samples[i]),
            .window       (channel_windows[i])
        );
    end

    event_collector u_event_collector (
        .clk                   (clk),
        .rst                   (rst),
        .windows               (channel_windows),
        .window_out            (window_out),
        .trigger_pattern_valid (trigger_pattern_valid),
        .trigger_pattern       (trigger_pattern),
        .event_count           (event_count)
    );

endmodule

//--- rtl/event_collector.sv
`timescale 1ns/100ps
`include "daq_defs.svh"

module event_collector
    import daq_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  window_sample_t               windows [`DAQ_NUM_CHANNELS],
    output window_sample_t               window_out [`DAQ_NUM_CHANNELS],
    output logic                         trigger_pattern_valid,
    output logic [`DAQ_NUM_CHANNELS-1:0] trigger_pattern,
    output logic [15:0]                  event_count
);

    logic [`DAQ_NUM_CHANNELS-1:0] first_bits;

    // window streams leave with the same one-cycle latency they arrive with
    always_comb begin
        for (int i = 0; i < `DAQ_NUM_CHANNELS; i++) begin
            window_out[i] = windows[i];
            first_bits[i] = windows[i].valid && windows[i].first;
        end
    end

    // coincident window starts share one pattern pulse and one count
    always_ff @(posedge clk) begin
        if (rst) begin
            trigger_pattern_valid <= 1'b0;
            trigger_pattern       <= '0;
            event_count           <= '0;
        end else begin
            trigger_pattern_valid <= |first_bits;
            trigger_pattern       <= first_bits;
            if (|first_bits) begin
                event_count <= event_count + 16'd1;
            end
        end
    end

endmodule

//--- tb/tb_top.sv
`timescale 1ns/100ps
`include "daq_defs.svh"

module tb_top
    import daq_pkg::*;
();

    localparam int clk_period    = 10;
    // the cycle budget counts two cycles per sample and per write and three per settle
    localparam int total_samples = 4 + 20 + 6 + 19 + 9;
    localparam int total_writes  = 0 + 1 + 1 + 3 + 2;
    localparam int total_cycles  = 3 + 2 * total_samples + 2 * total_writes + 5 * 3;
    localparam int margin_cycles = 100;

    logic                         clk;
    logic                         rst;
    logic                         cfg_write;
    trigger_control_t             cfg_data;
    logic                         sample_valid;
    sample_t                      adc_samples [`DAQ_NUM_CHANNELS];
    window_sample_t               window_out [`DAQ_NUM_CHANNELS];
    logic                         trigger_pattern_valid;
    logic [`DAQ_NUM_CHANNELS-1:0] trigger_pattern;
    logic [15:0]                  event_count;

    logic [31:0]      lcg_state = 32'hc1bbe9cb;
    trigger_control_t cur_ctrl;
    sample_t          bg_base;
    sample_t          hist [`DAQ_NUM_CHANNELS][0:511];
    int               n_samples = 0;
    window_sample_t   obs_win [$];
    int               obs_ch [$];
    logic [3:0]       pat_q [$];
    logic [3:0]       prev_first = '0;
    logic             strobe_seen = 1'b0;
    logic [15:0]      pulses_seen = '0;
    logic [15:0]      expected_events = '0;

    digitizer_trigger_top u_dut (
        .clk                   (clk),
        .rst                   (rst),
        .cfg_write             (cfg_write),
        .cfg_data              (cfg_data),
        .sample_valid          (sample_valid),
        .adc_samples           (adc_samples),
        .window_out            (window_out),
        .trigger_pattern_valid (trigger_pattern_valid),
        .trigger_pattern       (trigger_pattern),
        .event_count           (event_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("MISMATCH at %0t: %s got 0x%0h expected 0x%0h",
                               $time, name, got, exp));
        end
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // small offsets above the baseline stay well clear of every threshold
    function automatic sample_t background();
        logic [31:0] r;
        r = next_random();
        return bg_base + sample_t'({10'd0, r[21:16]});
    endfunction

    function automatic sample_t correct(input sample_t raw, input trigger_control_t c);
        sample_t base;
        sample_t diff;
        if (c.trigger_type[2]) begin
            base = {{(`DAQ_SAMPLE_WIDTH - `DAQ_HG_BASELINE_WIDTH)
                     {c.hg_baseline[`DAQ_HG_BASELINE_WIDTH-1]}}, c.hg_baseline};
        end else begin
            base = c.lg_baseline;
        end
        diff = raw - base;
        if (c.trigger_type[3]) begin
            diff = sample_t'(0) - diff;
        end
        return diff;
    endfunction

    function automatic trigger_control_t make_control(input acquire_mode_e mode,
        input logic [3:0] ttype, input int rise, input int fall, input int hg,
        input int lg, input int pre, input int post);
        trigger_control_t c;
        c                   = '0;
        c.acquire_mode      = mode;
        c.trigger_type      = ttype;
        c.rising_threshold  = threshold_t'(rise);
        c.falling_threshold = threshold_t'(fall);
        c.hg_baseline       = hg_baseline_t'(hg);
        c.lg_baseline       = lg_baseline_t'(lg);
        c.pre_length        = pre_length_t'(pre);
        c.post_length       = post_length_t'(post);
        return c;
    endfunction

    function automatic int bound_failures();
        return u_dut.gen_channel[0].u_trigger_channel.u_trigger_props.failures
             + u_dut.gen_channel[1].u_trigger_channel.u_trigger_props.failures
             + u_dut.gen_channel[2].u_trigger_channel.u_trigger_props.failures
             + u_dut.gen_channel[3].u_trigger_channel.u_trigger_props.failures;
    endfunction

    task automatic write_control(input trigger_control_t c);
        @(posedge clk);
        #1;
        cfg_data  = c;
        cfg_write = 1'b1;
        cur_ctrl  = c;
        @(posedge clk);
        #1;
        cfg_write = 1'b0;
    endtask

    task automatic drive_sample(input logic [3:0] hit_mask, input sample_t hit_value);
        int i;
        @(posedge clk);
        #1;
        for (i = 0; i < `DAQ_NUM_CHANNELS; i++) begin
            if (hit_mask[i]) begin
                adc_samples[i] = hit_value;
            end else begin
                adc_samples[i] = background();
            end
            hist[i][n_samples] = correct(adc_samples[i], cur_ctrl);
        end
        sample_valid = 1'b1;
        n_samples++;
        @(posedge clk);
        #1;
        sample_valid = 1'b0;
    endtask

    task automatic drive_background(input int count);
        int k;
        for (k = 0; k < count; k++) begin
            drive_sample(4'b0000, '0);
        end
    endtask

    task automatic settle();
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic take_entry(input int ch, output window_sample_t w);
        int k;
        int pos;
        pos = -1;
        for (k = obs_ch.size() - 1; k >= 0; k--) begin
            if (obs_ch[k] == ch) begin
                pos = k;
            end
        end
        if (pos < 0) begin
            w = '0;
            fail_run($sformatf("channel %0d emitted fewer window samples than expected", ch));
        end else begin
            w = obs_win[pos];
            obs_win.delete(pos);
            obs_ch.delete(pos);
        end
    endtask

    // a trigger on sample t emits t-pre through t+post unless count cuts the window short
    task automatic check_window(input int ch, input int t, input int pre, input int post,
                                input int count);
        int             j;
        window_sample_t w;
        for (j = 0; j < count; j++) begin
            take_entry(ch, w);
            check_value($sformatf("ch%0d window[%0d].sample", ch, j),
                        32'(w.sample), 32'(hist[ch][t - pre + j]));
            check_value($sformatf("ch%0d window[%0d].first", ch, j), 32'(w.first), 32'(j == 0));
            check_value($sformatf("ch%0d window[%0d].last", ch, j),
                        32'(w.last), 32'(j == pre + post));
        end
    endtask

    task automatic expect_pattern(input logic [3:0] p);
        logic [3:0] got;
        expected_events = expected_events + 16'd1;
        if (pat_q.size() == 0) begin
            fail_run("a trigger pattern pulse is missing");
        end else begin
            got = pat_q.pop_front();
            check_value("trigger_pattern", 32'(got), 32'(p));
        end
    endtask

    task automatic check_drained();
        check_value("extra window samples", obs_win.size(), 0);
        check_value("extra pattern pulses", pat_q.size(), 0);
    endtask

    task automatic quiet_after_reset();
        int k;
        for (k = 0; k < 4; k++) begin
            drive_sample(4'b1111, 16'sd20000);
        end
        settle();
        check_drained();
        check_value("event_count", 32'(event_count), 32'd0);
    endtask

    task automatic rising_continuous();
        int t1;
        int t2;
        bg_base = 16'sd100;
        write_control(make_control(ACQ_CONTINUOUS, 4'b0001, 1000, 0, 0, 100, 2, 3));
        drive_background(5);
        t1 = n_samples;
        drive_sample(4'b0001, 16'sd1600);
        // five samples finish the window and one more primes the edge compare
        drive_background(7);
        t2 = n_samples;
        drive_sample(4'b0001, 16'sd1600);
        drive_background(6);
        settle();
        check_window(0, t1, 2, 3, 6);
        check_window(0, t2, 2, 3, 6);
        expect_pattern(4'b0001);
        expect_pattern(4'b0001);
        check_drained();
    endtask

    task automatic falling_one_sample();
        int t;
        bg_base = -16'sd200;
        write_control(make_control(ACQ_CONTINUOUS, 4'b1110, 1000, -500, -200, 0, 0, 0));
        drive_background(3);
        t = n_samples;
        // the corrected value -(500 + 200) lies below the falling threshold
        drive_sample(4'b0100, 16'sd500);
        drive_background(2);
        settle();
        check_window(2, t, 0, 0, 1);
        expect_pattern(4'b0100);
        check_drained();
    endtask

    task automatic single_shot();
        trigger_control_t c;
        int               t1;
        int               t2;
        bg_base = 16'sd300;
        c = make_control(ACQ_SINGLE, 4'b0001, 1000, 0, 0, 300, 1, 1);
        write_control(c);
        drive_background(3);
        t1 = n_samples;
        drive_sample(4'b0001, 16'sd2300);
        drive_background(4);
        drive_sample(4'b0001, 16'sd2300);
        drive_background(3);
        write_control(make_control(ACQ_IDLE, 4'b0001, 1000, 0, 0, 300, 1, 1));
        write_control(c);
        drive_background(3);
        t2 = n_samples;
        drive_sample(4'b0001, 16'sd2300);
        drive_background(3);
        settle();
        check_window(0, t1, 1, 1, 3);
        check_window(0, t2, 1, 1, 3);
        expect_pattern(4'b0001);
        expect_pattern(4'b0001);
        check_drained();
    endtask

    task automatic coincident_and_stop();
        trigger_control_t c;
        int               t;
        bg_base = -16'sd50;
        c = make_control(ACQ_CONTINUOUS, 4'b0001, 1000, 0, 0, -50, 1, 4);
        write_control(c);
        drive_background(3);
        t = n_samples;
        drive_sample(4'b1010, 16'sd1950);
        drive_background(2);
        c.stop = 1'b1;
        write_control(c);
        drive_background(3);
        settle();
        check_window(1, t, 1, 4, 3);
        check_window(3, t, 1, 4, 3);
        expect_pattern(4'b1010);
        check_drained();
        check_value("event_count", 32'(event_count), 32'(expected_events));
    endtask

    always @(posedge clk) begin
        strobe_seen <= sample_valid;
    end

    // outputs are sampled on the falling edge half a cycle after they settle
    always @(negedge clk) begin
        int         i;
        logic [3:0] first_now;
        first_now = '0;
        if (!rst) begin
            if (bound_failures() != 0) begin
                fail_run("an assertion bound to a trigger channel failed");
            end
            check_value("trigger_pattern_valid", 32'(trigger_pattern_valid), 32'(|prev_first));
            if (trigger_pattern_valid) begin
                check_value("trigger_pattern", 32'(trigger_pattern), 32'(prev_first));
                pat_q.push_back(trigger_pattern);
                pulses_seen = pulses_seen + 16'd1;
            end
            check_value("event_count", 32'(event_count), 32'(pulses_seen));
            for (i = 0; i < `DAQ_NUM_CHANNELS; i++) begin
                if (window_out[i].valid) begin
                    if (!strobe_seen) begin
                        fail_run($sformatf("channel %0d emitted a window sample without a strobe",
                                           i));
                    end
                    obs_ch.push_back(i);
                    obs_win.push_back(window_out[i]);
                    first_now[i] = window_out[i].first;
                end
            end
        end
        prev_first = first_now;
    end

    initial begin
        #((total_cycles + margin_cycles) * clk_period);
        fail_run("timeout: the tests did not finish in the expected time");
    end

    initial begin
        int i;
        rst          = 1'b1;
        cfg_write    = 1'b0;
        cfg_data     = '0;
        sample_valid = 1'b0;
        bg_base      = '0;
        cur_ctrl     = '0;
        cur_ctrl.stop = 1'b1;
        for (i = 0; i < `DAQ_NUM_CHANNELS; i++) begin
            adc_samples[i] = '0;
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        quiet_after_reset();
        rising_continuous();
        falling_one_sample();
        single_shot();
        coincident_and_stop();
        if (bound_failures() != 0) begin
            fail_run("an assertion bound to a trigger channel failed");
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- tb/trigger_props.sv
`timescale 1ns/100ps

module trigger_props
    import daq_pkg::*;
(
    input logic             clk,
    input logic             rst,
    input trigger_control_t control,
    input window_sample_t   window
);

    int   failures;
    logic started;
    logic closed;

    initial failures = 0;

    // started marks a window start seen since the last reset or stop
    always_ff @(posedge clk) begin
        if (rst || control.stop) begin
            started <= 1'b0;
        end else if (window.valid && window.first) begin
            started <= 1'b1;
        end
    end

    // closed marks a last flag that no new window start has followed yet
    always_ff @(posedge clk) begin
        if (rst) begin
            closed <= 1'b0;
        end else if (window.valid && window.last) begin
            closed <= 1'b1;
        end else if (window.valid && window.first) begin
            closed <= 1'b0;
        end
    end

    a_valid_in_window: assert property (@(posedge clk) disable iff (rst)
        window.valid |-> (window.first || started))
        else begin
            failures++;
            $error("window sample outside a started window");
        end

    a_quiet_after_last: assert property (@(posedge clk) disable iff (rst)
        (window.valid && closed) |-> window.first)
        else begin
            failures++;
            $error("window sample follows a last flag");
        end

    a_quiet_when_stopped: assert property (@(posedge clk) disable iff (rst)
        control.stop |=> !window.valid)
        else begin
            failures++;
            $error("window sample while stop is high");
        end

endmodule

bind trigger_channel trigger_props u_trigger_props (
    .clk     (clk),
    .rst     (rst),
    .control (control),
    .window  (window)
);

//--- trigger_channel/trigger_channel.sv
`timescale 1ns/100ps
`include "daq_defs.svh"

module trigger_channel
    import daq_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  trigger_control_t control,
    input  logic             sample_valid,
    input  sample_t          adc_sample,
    output window_sample_t   window
);

    localparam int span_width  = $clog2(`DAQ_MAX_PRE_LENGTH + `DAQ_MAX_POST_LENGTH + 1);
    localparam int index_width = $clog2(`DAQ_MAX_PRE_LENGTH);

    typedef enum logic [1:0] {
        IDLE,
        ARMED,
        CAPTURE,
        DONE
    } state_e;

    state_e                state;
    state_e                state_next;
    state_e                end_state;
    logic [span_width-1:0] remaining;
    logic [span_width-1:0] remaining_next;
    logic [span_width-1:0] window_span;
    logic                  active;
    logic                  prev_valid;
    logic                  rising_hit;
    logic                  falling_hit;
    logic                  triggered;
    logic                  emit;
    logic                  emit_first;
    logic                  emit_last;
    pre_length_t           pre_eff;
    post_length_t          post_eff;
    logic [index_width-1:0] pre_index;
    sample_t               baseline;
    sample_t               difference;
    sample_t               corrected;
    sample_t               delayed;
    sample_t               delay_line [`DAQ_MAX_PRE_LENGTH];

    // baseline subtraction and optional polarity flip
    assign baseline   = control.trigger_type[2] ? sample_t'(control.hg_baseline)
                                                : control.lg_baseline;
    assign difference = adc_sample - baseline;
    assign corrected  = control.trigger_type[3] ? -difference : difference;

    // delay_line[0] holds the previous corrected sample
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            delay_line[0] <= corrected;
            for (int i = 1; i < `DAQ_MAX_PRE_LENGTH; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    assign rising_hit  = control.trigger_type[0]
                         && (delay_line[0] < control.rising_threshold)
                         && (corrected >= control.rising_threshold);
    assign falling_hit = control.trigger_type[1]
                         && (delay_line[0] > control.falling_threshold)
                         && (corrected <= control.falling_threshold);
    assign triggered   = prev_valid && (rising_hit || falling_hit);

    // a reserved mode acts like idle
    assign active = !control.stop
                    && (control.acquire_mode == ACQ_SINGLE
                        || control.acquire_mode == ACQ_CONTINUOUS);

    // out-of-range lengths are clamped to what the delay line can hold
    assign pre_eff  = (control.pre_length > pre_length_t'(`DAQ_MAX_PRE_LENGTH))
                      ? pre_length_t'(`DAQ_MAX_PRE_LENGTH) : control.pre_length;
    assign post_eff = (control.post_length > post_length_t'(`DAQ_MAX_POST_LENGTH))
                      ? post_length_t'(`DAQ_MAX_POST_LENGTH) : control.post_length;

    assign window_span = span_width'(pre_eff) + span_width'(post_eff);
    assign pre_index   = index_width'(pre_eff - pre_length_t'(1));
    assign delayed     = (pre_eff == '0) ? corrected : delay_line[pre_index];
    assign end_state   = (control.acquire_mode == ACQ_CONTINUOUS) ? ARMED : DONE;

    always_comb begin
        state_next     = state;
        remaining_next = remaining;
        emit           = 1'b0;
        emit_first     = 1'b0;
        emit_last      = 1'b0;
        case (state)
            IDLE: begin
                if (active) begin
                    state_next = ARMED;
                end
            end
            ARMED: begin
                if (!active) begin
                    state_next = IDLE;
                end else if (sample_valid && triggered) begin
                    emit       = 1'b1;
                    emit_first = 1'b1;
                    if (window_span == '0) begin
                        emit_last  = 1'b1;
                        state_next = end_state;
                    end else begin
                        remaining_next = window_span;
                        state_next     = CAPTURE;
                    end
                end
            end
            CAPTURE: begin
                // leaving mid-window drops the rest, last never goes out
                if (!active) begin
                    state_next = IDLE;
                end else if (sample_valid) begin
                    emit           = 1'b1;
                    remaining_next = remaining - span_width'(1);
                    if (remaining == span_width'(1)) begin
                        emit_last  = 1'b1;
                        state_next = end_state;
                    end
                end
            end
            DONE: begin
                // single shot waits here for stop or a mode change
                if (!active || control.acquire_mode != ACQ_SINGLE) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            remaining  <= '0;
            prev_valid <= 1'b0;
        end else begin
            state     <= state_next;
            remaining <= remaining_next;
            // the first sample seen after arming only primes the edge compare
            if (state != ARMED) begin
                prev_valid <= 1'b0;
            end else if (sample_valid) begin
                prev_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        window.sample <= delayed;
        if (rst) begin
            window.valid <= 1'b0;
            window.first <= 1'b0;
            window.last  <= 1'b0;
        end else begin
            window.valid <= emit;
            window.first <= emit_first;
            window.last  <= emit_last;
        end
    end

endmodule
